//--- Bender.yml
package:
  name: keypad_calc

sources:
  - files:
      - hdl/calc_arith_pkg.sv
      - hdl/keypad_pkg.sv
      - hdl/add_sub_unit.sv
      - hdl/seq_multiplier.sv
      - hdl/calc_controller.sv
      - hdl/calc_top.sv
  - target: test
    files:
      - verification/calc_tb.sv

//--- files.f
hdl/calc_arith_pkg.sv
hdl/keypad_pkg.sv
hdl/add_sub_unit.sv
hdl/seq_multiplier.sv
hdl/calc_controller.sv
hdl/calc_top.sv
verification/calc_tb.sv

//--- hdl/add_sub_unit.sv
`timescale 1ns/1ns

module add_sub_unit (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       start,
    input  calc_arith_pkg::arith_req_t req,
    output calc_arith_pkg::arith_rsp_t rsp,
    output logic                       done
);
    import calc_arith_pkg::*;

    operand_t sum;          // Combinational add or subtract
    operand_t result_q;     // Held until the next start

    // Both directions wrap modulo 2^16
    always_comb begin
        if (req.sub) begin
            sum = req.a - req.b;
        end else begin
            sum = req.a + req.b;
        end
    end

    // Single-cycle operation, done follows start directly
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result_q <= sum;    // Capture on start only
        end
    end

    assign rsp = '{result: result_q};

endmodule

//--- hdl/calc_arith_pkg.sv
package calc_arith_pkg;

    // Datapath word size, all arithmetic wraps at this width
    localparam int operand_width = 16;

    // Shift-and-add iterations, one multiplier bit per cycle
    localparam int mul_cycles    = 16;
    localparam int mul_cnt_width = $clog2(mul_cycles + 1);

    typedef logic [operand_width-1:0] operand_t;

    // One-hot operator code, same as the keypad operator lines
    typedef enum logic [2:0] {
        op_add = 3'b001,
        op_sub = 3'b010,
        op_mul = 3'b100
    } calc_op_t;

    // Request captured by a unit on start
    typedef struct packed {
        operand_t a;
        operand_t b;
        logic     sub;    // Adder only, selects a - b
    } arith_req_t;

    // Response, valid with the done pulse
    typedef struct packed {
        operand_t result;
    } arith_rsp_t;

endpackage

//--- hdl/calc_controller.sv
`timescale 1ns/1ns

module calc_controller (
    input  logic                       clk,
    input  logic                       nRST,
    input  keypad_pkg::key_event_t     key,
    input  logic                       key_valid,
    output logic                       key_ready,
    output calc_arith_pkg::arith_req_t add_req,
    output calc_arith_pkg::arith_req_t mul_req,
    output logic                       add_start,
    output logic                       mul_start,
    input  calc_arith_pkg::arith_rsp_t add_rsp,
    input  calc_arith_pkg::arith_rsp_t mul_rsp,
    input  logic                       add_done,
    input  logic                       mul_done,
    output logic                       complete,
    output calc_arith_pkg::operand_t   result
);
    import calc_arith_pkg::*;
    import keypad_pkg::*;

    typedef enum logic [2:0] {
        enter_first,     // Waiting for first operand digits or operator
        scale_first,     // Times-ten multiply in flight for operand one
        enter_second,    // Waiting for second operand digits or equal
        scale_second,    // Times-ten multiply in flight for operand two
        execute_wait,    // Final operation running
        show_result      // Result on display, complete set
    } state_t;

    state_t   state;
    state_t   next_state;
    operand_t first_op;
    operand_t second_op;
    operand_t entry_op;       // Operand being extended by the next digit
    operand_t scaled;         // Product plus pending digit
    calc_op_t op_latch;
    digit_t   pending_digit;
    logic     have_digits;    // At least one digit in the current operand
    logic     take;
    logic     digit_ok;
    logic     op_ok;
    logic     take_digit;
    logic     take_op;
    logic     take_equal;
    logic     exec_done;

    assign take     = key_valid && key_ready;
    assign digit_ok = (key.kind == key_digit) && (key.digit <= max_digit);
    assign op_ok    = (key.kind == key_op) && (key.op inside {op_add, op_sub, op_mul});

    // Ready is only high in the entry states, so a digit is always usable
    assign take_digit = take && digit_ok;
    assign take_op    = take && op_ok && (state == enter_first) && have_digits;
    assign take_equal = take && (key.kind == key_equal) && (state == enter_second)
                        && have_digits;

    assign exec_done = (op_latch == op_mul) ? mul_done : add_done;

    // A digit after a shown result starts over from zero
    always_comb begin
        case (state)
            enter_second: entry_op = second_op;
            show_result:  entry_op = '0;
            default:      entry_op = first_op;
        endcase
    end

    assign scaled = mul_rsp.result + operand_t'(pending_digit);

    always_comb begin
        next_state = state;
        case (state)
            enter_first: begin
                if (take_digit) begin
                    next_state = scale_first;
                end else if (take_op) begin
                    next_state = enter_second;
                end
            end
            scale_first: begin
                if (mul_done) begin
                    next_state = enter_first;
                end
            end
            enter_second: begin
                if (take_digit) begin
                    next_state = scale_second;
                end else if (take_equal) begin
                    next_state = execute_wait;
                end
            end
            scale_second: begin
                if (mul_done) begin
                    next_state = enter_second;
                end
            end
            execute_wait: begin
                if (exec_done) begin
                    next_state = show_result;
                end
            end
            show_result: begin
                if (take_digit) begin
                    next_state = scale_first;
                end
            end
            default: begin
                next_state = enter_first;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state         <= enter_first;
            key_ready     <= 1'b0;
            complete      <= 1'b0;
            result        <= '0;
            first_op      <= '0;
            second_op     <= '0;
            op_latch      <= op_add;
            pending_digit <= '0;
            have_digits   <= 1'b0;
            add_start     <= 1'b0;
            mul_start     <= 1'b0;
        end else begin
            state     <= next_state;
            // Drops for a cycle after an accepted operator
            key_ready <= !take_op &&
                         (next_state inside {enter_first, enter_second, show_result});
            add_start <= 1'b0;
            mul_start <= 1'b0;

            if (take_digit) begin
                pending_digit <= key.digit;
                mul_start     <= 1'b1;          // Times-ten step
                if (state == show_result) begin
                    complete    <= 1'b0;
                    first_op    <= '0;
                    second_op   <= '0;
                    have_digits <= 1'b0;
                end
            end

            if (take_op) begin
                op_latch    <= key.op;
                have_digits <= 1'b0;            // Second operand starts empty
            end

            if (take_equal) begin
                if (op_latch == op_mul) begin
                    mul_start <= 1'b1;
                end else begin
                    add_start <= 1'b1;
                end
            end

            if (mul_done && (state == scale_first)) begin
                first_op    <= scaled;
                have_digits <= 1'b1;
            end
            if (mul_done && (state == scale_second)) begin
                second_op   <= scaled;
                have_digits <= 1'b1;
            end

            if (exec_done && (state == execute_wait)) begin
                result   <= (op_latch == op_mul) ? mul_rsp.result : add_rsp.result;
                complete <= 1'b1;
            end
        end
    end

    // Request payload, sampled by the units with their start strobes
    always_ff @(posedge clk) begin
        if (take_digit) begin
            mul_req <= '{a: entry_op, b: operand_t'(digit_base), sub: 1'b0};
        end else if (take_equal) begin
            mul_req <= '{a: first_op, b: second_op, sub: 1'b0};
            add_req <= '{a: first_op, b: second_op, sub: (op_latch == op_sub)};
        end
    end

endmodule

//--- hdl/calc_top.sv
`timescale 1ns/1ns

module calc_top (
    input  logic                     clk,
    input  logic                     nRST,
    input  keypad_pkg::key_event_t   key,
    input  logic                     key_valid,
    output logic                     key_ready,
    output logic                     complete,
    output calc_arith_pkg::operand_t result
);
    import calc_arith_pkg::*;

    arith_req_t add_req;
    arith_req_t mul_req;
    arith_rsp_t add_rsp;
    arith_rsp_t mul_rsp;
    logic       add_start;
    logic       mul_start;
    logic       add_done;
    logic       mul_done;

    calc_controller i_controller (
        .clk       (clk),
        .nRST      (nRST),
        .key       (key),
        .key_valid (key_valid),
        .key_ready (key_ready),
        .add_req   (add_req),
        .mul_req   (mul_req),
        .add_start (add_start),
        .mul_start (mul_start),
        .add_rsp   (add_rsp),
        .mul_rsp   (mul_rsp),
        .add_done  (add_done),
        .mul_done  (mul_done),
        .complete  (complete),
        .result    (result)
    );

    // Add and subtract share this unit
    add_sub_unit i_add_sub (
        .clk   (clk),
        .nRST  (nRST),
        .start (add_start),
        .req   (add_req),
        .rsp   (add_rsp),
        .done  (add_done)
    );

    // Used for digit scaling and for the multiply operator
    seq_multiplier i_mult (
        .clk   (clk),
        .nRST  (nRST),
        .start (mul_start),
        .req   (mul_req),
        .rsp   (mul_rsp),
        .done  (mul_done)
    );

endmodule

//--- hdl/keypad_pkg.sv
package keypad_pkg;

    typedef logic [3:0] digit_t;

    // What the key strobe carries
    typedef enum logic [1:0] {
        key_digit = 2'd0,
        key_op    = 2'd1,
        key_equal = 2'd2
    } key_kind_t;

    // One keypad event, only the field matching kind is meaningful
    typedef struct packed {
        key_kind_t                kind;
        digit_t                   digit;
        calc_arith_pkg::calc_op_t op;
    } key_event_t;

    localparam int     digit_base = 10;     // Decimal entry
    localparam digit_t max_digit  = 4'd9;   // Anything above is dropped

endpackage

//--- hdl/seq_multiplier.sv
`timescale 1ns/1ns

module seq_multiplier (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       start,
    input  calc_arith_pkg::arith_req_t req,
    output calc_arith_pkg::arith_rsp_t rsp,
    output logic                       done
);
    import calc_arith_pkg::*;

    operand_t                 mcand;     // Multiplicand, shifted left each step
    operand_t                 mplier;    // Multiplier, shifted right each step
    operand_t                 acc;       // Partial product, low bits only
    logic [mul_cnt_width-1:0] count;     // Iterations still to run
    logic                     busy;
    logic                     last_step;

    assign last_step = busy && (count == mul_cnt_width'(1));

    // Iteration control
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= last_step;      // Pulse after the final add
            if (start) begin
                busy  <= 1'b1;
                count <= mul_cnt_width'(mul_cycles);
            end else if (busy) begin
                count <= count - mul_cnt_width'(1);
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Shift-and-add datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= req.a;
            mplier <= req.b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;     // Overflow past bit 15 is dropped
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Accumulator stays put once busy falls, so the product holds
    assign rsp = '{result: acc};

endmodule

//--- verification/calc_tb.sv
`timescale 1ns/1ns

module calc_tb;
    import calc_arith_pkg::*;
    import keypad_pkg::*;

    localparam int clk_period     = 8;
    localparam int reset_cycles   = 5;
    localparam int directed_calcs = 7;
    localparam int random_calcs   = 20;
    localparam int max_digits     = 6;                  // Longest operand entered
    localparam int digit_cycles   = mul_cycles + 4;     // Scale step plus key handshake
    localparam int hold_cycles    = 4;
    localparam int calc_cycles    = 2 * max_digits * digit_cycles + 2 + digit_cycles + 16;
    localparam int timeout_ns     =
        2 * ((directed_calcs + random_calcs) * calc_cycles + 20) * clk_period;

    logic       clk;
    logic       nRST;
    key_event_t key;
    logic       key_valid;
    logic       key_ready;
    logic       complete;
    operand_t   result;

    integer     seed = 32'h1e14_387f;
    int unsigned a_val;
    int unsigned b_val;
    calc_op_t   rand_op;

    calc_top i_dut (
        .clk       (clk),
        .nRST      (nRST),
        .key       (key),
        .key_valid (key_valid),
        .key_ready (key_ready),
        .complete  (complete),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_failed();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_failed();
    endtask

    function automatic key_event_t key_event(input key_kind_t kind, input digit_t digit,
                                             input calc_op_t op);
        key_event_t k;
        k.kind  = kind;
        k.digit = digit;
        k.op    = op;
        return k;
    endfunction

    // Reference model with 16-bit wrap
    function automatic operand_t expected_result(input calc_op_t op, input operand_t a,
                                                 input operand_t b);
        logic [31:0] wide;
        case (op)
            op_add:  wide = 32'(a) + 32'(b);
            op_sub:  wide = 32'(a) - 32'(b);
            default: wide = 32'(a) * 32'(b);
        endcase
        return wide[operand_width-1:0];
    endfunction

    // Offer a key and hold it until the DUT takes it
    task automatic press_key(input key_event_t k);
        @(posedge clk);
        key       <= k;
        key_valid <= 1'b1;
        @(negedge clk);
        while (!key_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                 // Taken on this edge
        key_valid <= 1'b0;
    endtask

    // Key that must leave the entry state untouched
    task automatic press_ignored(input key_event_t k);
        press_key(k);
        @(negedge clk);
        assert (key_ready) else flag_mismatch("key_ready", key_ready, 1);
        assert (!complete) else flag_mismatch("complete", complete, 0);
    endtask

    // Decimal entry with the most significant digit first
    task automatic enter_operand(input int unsigned value, output operand_t entered);
        int unsigned digits[$];
        int unsigned rest;
        rest = value;
        do begin
            digits.push_front(rest % 10);
            rest = rest / 10;
        end while (rest != 0);
        entered = '0;
        foreach (digits[i]) begin
            press_key(key_event(key_digit, digit_t'(digits[i]), op_add));
            entered = operand_t'(entered * digit_base + digits[i]);
            @(negedge clk);
            assert (!complete) else flag_mismatch("complete", complete, 0);
        end
    endtask

    task automatic wait_result(input operand_t expected);
        @(negedge clk);
        while (!complete) begin
            @(negedge clk);
        end
        assert (result == expected) else flag_mismatch("result", result, expected);
        // Display must hold while nothing is pressed
        repeat (hold_cycles) begin
            @(negedge clk);
            assert (complete) else flag_mismatch("complete", complete, 1);
            assert (result == expected) else flag_mismatch("result", result, expected);
            assert (key_ready) else flag_mismatch("key_ready", key_ready, 1);
        end
    endtask

    task automatic run_calc(input int unsigned first_val, input calc_op_t op,
                            input int unsigned second_val, input bit add_ignored);
        operand_t a;
        operand_t b;
        enter_operand(first_val, a);
        if (add_ignored) begin
            press_ignored(key_event(key_digit, 4'hc, op_add));
            press_ignored(key_event(key_op, 4'h0, calc_op_t'(3'b011)));
            press_ignored(key_event(key_equal, 4'h0, op_add));  // Too early
        end
        press_key(key_event(key_op, 4'h0, op));
        enter_operand(second_val, b);
        if (add_ignored) begin
            press_ignored(key_event(key_digit, 4'hf, op_add));
        end
        press_key(key_event(key_equal, 4'h0, op_add));
        wait_result(expected_result(op, a, b));
    endtask

    initial begin
        nRST      = 1'b0;
        key       = '0;
        key_valid = 1'b0;

        repeat (reset_cycles) begin
            @(negedge clk);
            assert (!complete) else flag_mismatch("complete", complete, 0);
            assert (result == '0) else flag_mismatch("result", result, 0);
            assert (!key_ready) else flag_mismatch("key_ready", key_ready, 0);
        end
        @(posedge clk);
        nRST <= 1'b1;

        // Ready comes up one cycle after release
        @(negedge clk);
        assert (!key_ready) else flag_mismatch("key_ready", key_ready, 0);
        @(negedge clk);
        assert (key_ready) else flag_mismatch("key_ready", key_ready, 1);
        repeat (3) begin
            @(negedge clk);
            assert (key_ready) else flag_mismatch("key_ready", key_ready, 1);
            assert (!complete) else flag_mismatch("complete", complete, 0);
            assert (result == '0) else flag_mismatch("result", result, 0);
        end

        run_calc(1234, op_add, 5678, 1'b0);
        run_calc(60000, op_add, 7000, 1'b0);    // Sum wraps
        run_calc(250, op_sub, 1000, 1'b0);      // Negative difference wraps
        run_calc(9000, op_sub, 123, 1'b0);
        run_calc(300, op_mul, 400, 1'b0);
        run_calc(123456, op_mul, 7, 1'b0);      // Six digits overflow during entry
        run_calc(42, op_add, 17, 1'b1);

        for (int n = 0; n < random_calcs; n++) begin
            a_val = $unsigned($random(seed)) % 10000;
            b_val = $unsigned($random(seed)) % 10000;
            case ($unsigned($random(seed)) % 3)
                0:       rand_op = op_add;
                1:       rand_op = op_sub;
                default: rand_op = op_mul;
            endcase
            run_calc(a_val, rand_op, b_val, 1'b0);
        end

        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog sized from the number of calculations
    initial begin
        #(timeout_ns);
        $display("Timeout: the calculator did not finish within %0d ns", timeout_ns);
        stop_failed();
    end

endmodule
